// File: design/cfg_reg_bank.sv
module cfg_reg_bank (
    input  logic                     slow_clk,
    input  logic                     resetS,
    input  logic                     wr_en,          // one cycle write strobe
    input  clk_synth_pkg::reg_addr_t wr_addr,
    input  clk_synth_pkg::reg_word_t wr_data,
    input  logic                     load_defaults,  // startup reload strobe
    input  clk_synth_pkg::reg_addr_t rd_index,       // send index from sequencer
    output clk_synth_pkg::reg_word_t rd_word,
    output logic                     go
);

    // synth words, stored in send order (not chip register order)
    clk_synth_pkg::reg_word_t synth_regs [clk_synth_pkg::NUM_SYNTH_REGS];

    // ****************************************
    // synth word registers
    // ****************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS || load_defaults)
        begin
            // both reset and the startup strobe put the table back
            for (int i = 0; i < clk_synth_pkg::NUM_SYNTH_REGS; i++)
            begin
                synth_regs[i] <= clk_synth_pkg::CS_DEFAULTS[i];
            end
        end
        else if (wr_en && (wr_addr < clk_synth_pkg::CTRL_ADDR))
        begin
            synth_regs[wr_addr] <= wr_data;  // addr 0..16 only
        end
    end

    // ****************************************
    // control register
    // ****************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
            go <= 1'b0;                      // nothing starts out of reset
        else if (load_defaults)
            go <= 1'b1;                      // first config comes from startup
        else if (wr_en && (wr_addr == clk_synth_pkg::CTRL_ADDR))
            go <= wr_data[0];
        // anything above CTRL_ADDR just falls through
    end

    // indexed read, combinational so the sequencer sees writes up to the load
    always_comb
    begin
        if (rd_index < clk_synth_pkg::CTRL_ADDR)
            rd_word = synth_regs[rd_index];
        else
            rd_word = '0;                    // out of range index reads zero
    end

    // startup must reload exactly once, a held strobe would swallow the go edge
    a_load_one_shot : assert property (@(posedge slow_clk) disable iff (resetS)
        load_defaults |=> !load_defaults);

endmodule

// File: design/clk_synth_cfg.sv
module clk_synth_cfg #(
    parameter int STARTUP_WAIT_CYCLES = 32768  // settle time before first config
) (
    input  logic                     slow_clk,
    input  logic                     resetS,
    input  logic                     wr_en,
    input  clk_synth_pkg::reg_addr_t wr_addr,
    input  clk_synth_pkg::reg_word_t wr_data,
    output logic                     dclk,
    output logic                     ddat,
    output logic                     dlen,
    output logic                     sync
);

    logic                     load_defaults;
    logic                     startup_done;
    logic                     go;
    clk_synth_pkg::reg_addr_t rd_index;
    clk_synth_pkg::reg_word_t rd_word;
    logic                     shift_req;
    logic                     shift_ack;
    clk_synth_pkg::reg_word_t shift_word;

    // chip samples on dclk rising, i.e. mid slow_clk cycle
    assign dclk = ~slow_clk;

    // ****************************************
    // blocks
    // ****************************************
    cfg_reg_bank u_bank (
        .slow_clk      (slow_clk),
        .resetS        (resetS),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .load_defaults (load_defaults),
        .rd_index      (rd_index),
        .rd_word       (rd_word),
        .go            (go)
    );

    startup_seq #(
        .STARTUP_WAIT_CYCLES (STARTUP_WAIT_CYCLES)
    ) u_startup (
        .slow_clk      (slow_clk),
        .resetS        (resetS),
        .load_defaults (load_defaults),
        .startup_done  (startup_done)
    );

    write_seq u_write (
        .slow_clk     (slow_clk),
        .resetS       (resetS),
        .go           (go),
        .startup_done (startup_done),
        .rd_word      (rd_word),
        .shift_ack    (shift_ack),
        .rd_index     (rd_index),
        .shift_req    (shift_req),
        .shift_word   (shift_word),
        .sync         (sync)
    );

    serial_shifter u_shift (
        .slow_clk   (slow_clk),
        .resetS     (resetS),
        .shift_req  (shift_req),
        .shift_word (shift_word),
        .shift_ack  (shift_ack),
        .ddat       (ddat),
        .dlen       (dlen)
    );

endmodule

// File: design/clk_synth_pkg.sv
package clk_synth_pkg;

    // ****************************************
    // widths and counts
    // ****************************************
    localparam int WORD_W          = 32;  // synth word and bus data
    localparam int ADDR_W          = 5;   // bus address and send index
    localparam int NUM_SYNTH_REGS  = 17;  // words per sequence
    localparam int SYNC_LOW_CYCLES = 16;  // sync low time after a sequence

    typedef logic [WORD_W-1:0] reg_word_t;
    typedef logic [ADDR_W-1:0] reg_addr_t;

    // control register sits right after the last synth word, bit 0 is go
    localparam reg_addr_t CTRL_ADDR = 5'd17;

    // ****************************************
    // default words, in send order
    // ****************************************
    // low 5 bits carry the chip register number
    // chip reg 7 goes out twice: reset bit set first, then cleared
    localparam reg_word_t CS_DEFAULTS [NUM_SYNTH_REGS] = '{
        32'h8000_0007,  // chip reg 7, reset asserted
        32'h0001_0100,  // chip reg 0
        32'h0001_0101,  // chip reg 1
        32'h0001_0102,  // chip reg 2
        32'h0001_0103,  // chip reg 3
        32'h0001_0104,  // chip reg 4
        32'h0001_0105,  // chip reg 5
        32'h0001_0106,  // chip reg 6
        32'h0000_0007,  // chip reg 7, reset released
        32'h1000_0908,  // chip reg 8
        32'hA000_2209,  // chip reg 9
        32'h0082_800A,  // chip reg 10
        32'h6400_000B,  // chip reg 11
        32'h0300_000C,  // chip reg 12
        32'h0000_000D,  // chip reg 13
        32'h0003_000E,  // chip reg 14
        32'h0000_100F   // chip reg 15
    };

endpackage

// File: design/serial_shifter.sv
module serial_shifter (
    input  logic                     slow_clk,
    input  logic                     resetS,
    input  logic                     shift_req,
    input  clk_synth_pkg::reg_word_t shift_word,
    output logic                     shift_ack,
    output logic                     ddat,
    output logic                     dlen       // active low latch enable
);

    localparam int BIT_CNT_W = $clog2(clk_synth_pkg::WORD_W);
    localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(clk_synth_pkg::WORD_W - 1);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_SHIFT = 2'd1;
    localparam logic [1:0] S_ACK   = 2'd2;   // wait for req to drop

    logic [1:0]               state;
    clk_synth_pkg::reg_word_t sreg;          // MSB drives the line
    logic [BIT_CNT_W-1:0]     bit_cnt;

    // ****************************************
    // shift register
    // ****************************************
    always_ff @(posedge slow_clk)
    begin
        if ((state == S_IDLE) && shift_req)
            sreg <= shift_word;
        else if (state == S_SHIFT)
            sreg <= {sreg[clk_synth_pkg::WORD_W-2:0], 1'b0};
    end

    // framing and ack
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state     <= S_IDLE;
            dlen      <= 1'b1;
            shift_ack <= 1'b0;
            bit_cnt   <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (shift_req)
                    begin
                        dlen    <= 1'b0;   // window opens next cycle
                        bit_cnt <= '0;
                        state   <= S_SHIFT;
                    end
                end
                S_SHIFT:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_LAST)
                    begin
                        dlen      <= 1'b1;  // latch, ack on the same edge
                        shift_ack <= 1'b1;
                        state     <= S_ACK;
                    end
                end
                S_ACK:
                begin
                    if (!shift_req)
                    begin
                        shift_ack <= 1'b0;
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign ddat = sreg[clk_synth_pkg::WORD_W-1] & ~dlen;  // low outside the window

    a_dlen_window : assert property (@(posedge slow_clk) disable iff (resetS)
        $fell(dlen) |-> ##[1:32] dlen);
    a_ack_on_req : assert property (@(posedge slow_clk) disable iff (resetS)
        $rose(shift_ack) |-> shift_req);

endmodule

// File: design/startup_seq.sv
module startup_seq #(
    parameter int STARTUP_WAIT_CYCLES = 32768
) (
    input  logic slow_clk,
    input  logic resetS,
    output logic load_defaults,  // one cycle, reload defaults and set go
    output logic startup_done    // held until next reset
);

    // wait counter sized from the parameter
    localparam int CNT_W = $clog2(STARTUP_WAIT_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STARTUP_WAIT_CYCLES - 1);

    // ****************************************
    // states
    // ****************************************
    localparam logic [1:0] S_WAIT   = 2'd0;  // power-up settle time
    localparam logic [1:0] S_RELOAD = 2'd1;  // single reload cycle
    localparam logic [1:0] S_DONE   = 2'd2;  // parked

    logic [1:0]       state;
    logic [CNT_W-1:0] wait_cnt;

    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state    <= S_WAIT;
            wait_cnt <= '0;
        end
        else
        begin
            case (state)
                S_WAIT:
                begin
                    if (wait_cnt == CNT_LAST)
                        state <= S_RELOAD;
                    else
                        wait_cnt <= wait_cnt + 1'b1;
                end
                S_RELOAD: state <= S_DONE;
                S_DONE:   state <= S_DONE;   // only a reset gets us out
                default:  state <= S_WAIT;
            endcase
        end
    end

    // outputs decoded straight from state
    assign load_defaults = (state == S_RELOAD);
    assign startup_done  = (state == S_DONE);

endmodule

// File: design/write_seq.sv
module write_seq (
    input  logic                     slow_clk,
    input  logic                     resetS,
    input  logic                     go,            // control reg bit 0
    input  logic                     startup_done,  // enables sync pulse
    input  clk_synth_pkg::reg_word_t rd_word,
    input  logic                     shift_ack,
    output clk_synth_pkg::reg_addr_t rd_index,
    output logic                     shift_req,
    output clk_synth_pkg::reg_word_t shift_word,
    output logic                     sync
);

    localparam clk_synth_pkg::reg_addr_t LAST_INDEX =
        clk_synth_pkg::reg_addr_t'(clk_synth_pkg::NUM_SYNTH_REGS - 1);
    localparam int SYNC_CNT_W = $clog2(clk_synth_pkg::SYNC_LOW_CYCLES + 1);
    localparam logic [SYNC_CNT_W-1:0] SYNC_LAST =
        SYNC_CNT_W'(clk_synth_pkg::SYNC_LOW_CYCLES - 1);

    // ****************************************
    // states
    // ****************************************
    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_ISSUE     = 3'd1;  // latch word, raise req
    localparam logic [2:0] S_WAIT_ACK  = 3'd2;  // frame on the wire
    localparam logic [2:0] S_WAIT_DROP = 3'd3;  // req low, wait ack low
    localparam logic [2:0] S_SYNC      = 3'd4;  // sync held low

    logic [2:0]               state;
    logic                     go_q;
    logic                     go_rise;
    logic                     start_pend;  // go edge seen, not yet served
    logic                     start_take;  // pending start consumed this cycle
    clk_synth_pkg::reg_addr_t send_idx;
    logic [SYNC_CNT_W-1:0]    sync_cnt;

    assign go_rise  = go & ~go_q;
    assign rd_index = send_idx;

    // a start is taken from idle, or between frames once the slave has let go
    assign start_take = start_pend &&
                        ((state == S_IDLE) || ((state == S_WAIT_DROP) && !shift_ack));

    // go edge detect, the edge is held until a sequence picks it up
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            go_q       <= 1'b0;
            start_pend <= 1'b0;
        end
        else
        begin
            go_q <= go;
            if (go_rise)
                start_pend <= 1'b1;
            else if (start_take)
                start_pend <= 1'b0;
        end
    end

    // ****************************************
    // register loop and req/ack master
    // ****************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state     <= S_IDLE;
            send_idx  <= '0;
            shift_req <= 1'b0;
            sync      <= 1'b1;    // sync idles high
            sync_cnt  <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (start_take)
                    begin
                        send_idx <= '0;
                        state    <= S_ISSUE;
                    end
                end
                S_ISSUE:
                begin
                    shift_req <= 1'b1;   // shift_word loads on the same edge
                    state     <= S_WAIT_ACK;
                end
                S_WAIT_ACK:
                begin
                    if (shift_ack)
                    begin
                        shift_req <= 1'b0;
                        state     <= S_WAIT_DROP;
                    end
                end
                S_WAIT_DROP:
                begin
                    if (!shift_ack)
                    begin
                        if (start_take)
                        begin
                            send_idx <= '0;  // new go edge restarts the loop
                            state    <= S_ISSUE;
                        end
                        else if (send_idx != LAST_INDEX)
                        begin
                            send_idx <= send_idx + 1'b1;
                            state    <= S_ISSUE;
                        end
                        else if (startup_done)
                        begin
                            sync     <= 1'b0;  // all words out, pulse sync
                            sync_cnt <= '0;
                            state    <= S_SYNC;
                        end
                        else
                            state <= S_IDLE;
                    end
                end
                S_SYNC:
                begin
                    sync_cnt <= sync_cnt + 1'b1;
                    if (sync_cnt == SYNC_LAST)
                    begin
                        sync  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // word captured as the request goes up, later bus writes do not disturb the frame
    always_ff @(posedge slow_clk)
    begin
        if (state == S_ISSUE)
            shift_word <= rd_word;
    end

    // four-phase rule: req only drops once the slave has acked
    a_req_held : assert property (@(posedge slow_clk) disable iff (resetS)
        $fell(shift_req) |-> shift_ack);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the testbench printed its pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_clk_synth_cfg \
    -Mdir obj_dir -o sim_tb \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_tb | tee /dev/stderr | grep -qx "TEST PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tests/clk_synth_cases.txt
# op a b, numbers in hex. D idx word = default word, W addr data = bus write, G val = go,
# E first last = expect frames first..last, S len = sync low cycles, N cyc = quiet, R = reset
D 00 80000007
D 01 00010100
D 02 00010101
D 03 00010102
D 04 00010103
D 05 00010104
D 06 00010105
D 07 00010106
D 08 00000007
D 09 10000908
D 0A A0002209
D 0B 0082800A
D 0C 6400000B
D 0D 0300000C
D 0E 0000000D
D 0F 0003000E
D 10 0000100F
# startup sequence with defaults
E 00 10
S 10
# new word at index 5
W 05 5A5A1205
G 0
G 1
E 00 10
S 10
# go already set
G 1
N C8
# address out of range
W 14 DEADBEEF
G 0
G 1
E 00 10
S 10
# reset in mid sequence
W 09 12340009
G 0
G 1
E 00 03
R
E 00 10
S 10

// File: tests/tb_clk_synth_cfg.sv
module tb_clk_synth_cfg;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int STARTUP_WAIT = 100;  // short power-up wait for simulation
    localparam int RESET_CYCLES = 5;
    localparam int NUM_WORDS    = 17;   // words per sequence
    localparam int FRAME_BITS   = 32;

    logic                     slow_clk;
    logic                     resetS;
    logic                     wr_en;
    clk_synth_pkg::reg_addr_t wr_addr;
    clk_synth_pkg::reg_word_t wr_data;
    logic                     dclk;
    logic                     ddat;
    logic                     dlen;
    logic                     sync;

    // one entry per case file operation line
    byte unsigned op_q [$];
    logic [31:0]  arg_a_q [$];
    logic [31:0]  arg_b_q [$];

    clk_synth_pkg::reg_word_t dflt_words [NUM_WORDS];  // D lines
    clk_synth_pkg::reg_word_t exp_words [NUM_WORDS];   // what the next sequence should send

    // seen on the wire
    clk_synth_pkg::reg_word_t frame_q [$];
    int                       frame_bits_q [$];
    int                       sync_len_q [$];

    clk_synth_pkg::reg_word_t shift_acc = '0;
    int                       bit_cnt   = 0;
    int                       sync_cnt  = 0;
    int                       cycle_cnt   = 0;
    int                       cycle_limit = 0;  // set once the cases are read

    clk_synth_cfg #(
        .STARTUP_WAIT_CYCLES (STARTUP_WAIT)
    ) dut (
        .slow_clk (slow_clk),
        .resetS   (resetS),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .dclk     (dclk),
        .ddat     (ddat),
        .dlen     (dlen),
        .sync     (sync)
    );

    initial
    begin
        slow_clk = 1'b0;
        forever #10 slow_clk = ~slow_clk;  // 20 ns period
    end

    // ****************************************
    // frame and sync monitors
    // ****************************************
    always @(posedge slow_clk)
    begin
        if (resetS)
        begin
            bit_cnt  = 0;                  // drop any half frame
            sync_cnt = 0;
        end
        else
        begin
            if (!dlen)
            begin
                shift_acc = {shift_acc[30:0], ddat};  // msb comes first
                bit_cnt++;
            end
            else if (bit_cnt != 0)
            begin
                frame_q.push_back(shift_acc);         // frame latched as dlen goes back high
                frame_bits_q.push_back(bit_cnt);
                bit_cnt = 0;
            end
            if (!sync)
                sync_cnt++;
            else if (sync_cnt != 0)
            begin
                sync_len_q.push_back(sync_cnt);
                sync_cnt = 0;
            end
        end
    end

    // run limit grows with the number of frames and waits in the case file
    always @(posedge slow_clk)
    begin
        cycle_cnt++;
        if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit))
        begin
            $display("timeout waiting for expected output");
            $display("TEST FAIL");
            $fatal(1, "run stopped at cycle %0d", cycle_cnt);
        end
    end

    // ****************************************
    // compare tasks
    // ****************************************
    task automatic report_mismatch(input string msg);
        $display("FAIL @ %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_word(input string what, input clk_synth_pkg::reg_word_t got,
                              input clk_synth_pkg::reg_word_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
            report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    // ****************************************
    // stimulus
    // ****************************************
    task automatic idle_gap();
        int n;
        n = $urandom % 8;                  // 0 to 7 idle cycles
        repeat (n) @(posedge slow_clk);
    endtask

    task automatic bus_write(input clk_synth_pkg::reg_addr_t addr,
                             input clk_synth_pkg::reg_word_t data);
        @(posedge slow_clk);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge slow_clk);
        wr_en   <= 1'b0;                   // single cycle strobe
    endtask

    task automatic apply_reset();
        @(posedge slow_clk);
        resetS <= 1'b1;
        @(posedge slow_clk);               // dut takes reset on this edge
        @(posedge slow_clk);
        check_level("dlen in reset", dlen, 1'b1);
        check_level("sync in reset", sync, 1'b1);
        check_level("ddat in reset", ddat, 1'b0);
        repeat (RESET_CYCLES - 2) @(posedge slow_clk);
        resetS <= 1'b0;
        frame_q.delete();
        frame_bits_q.delete();
        sync_len_q.delete();
        exp_words = dflt_words;            // bank is back on its defaults
    endtask

    // dclk low while slow_clk is high and high while it is low
    task automatic check_dclk();
        @(posedge slow_clk);
        #5;
        check_level("dclk in clock high phase", dclk, 1'b0);
        @(negedge slow_clk);
        #5;
        check_level("dclk in clock low phase", dclk, 1'b1);
    endtask

    task automatic expect_frames(input int first, input int last);
        clk_synth_pkg::reg_word_t got;
        int                       bits;
        for (int i = first; i <= last; i++)
        begin
            while (frame_q.size() == 0)
                @(posedge slow_clk);
            got  = frame_q.pop_front();
            bits = frame_bits_q.pop_front();
            check_count($sformatf("frame %0d length", i), bits, FRAME_BITS);
            check_word($sformatf("frame %0d word", i), got, exp_words[i]);
            check_count($sformatf("sync pulses before frame %0d", i), sync_len_q.size(), 0);
        end
        check_dclk();
    endtask

    task automatic expect_sync(input int len);
        int got;
        while (sync_len_q.size() == 0)
            @(posedge slow_clk);
        got = sync_len_q.pop_front();
        check_count("sync low length", got, len);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles)
        begin
            @(posedge slow_clk);
            check_level("dlen while quiet", dlen, 1'b1);
            check_level("sync while quiet", sync, 1'b1);
        end
        check_count("frames while quiet", frame_q.size(), 0);
    endtask

    // ****************************************
    // case file reader
    // ****************************************
    task automatic load_cases();
        int           fd;
        int           code;
        string        line;
        byte unsigned op;
        logic [31:0]  a;
        logic [31:0]  b;
        fd = $fopen("tests/clk_synth_cases.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the case file tests/clk_synth_cases.txt");
            $display("TEST FAIL");
            $fatal(1, "no case file");
        end
        cycle_limit = RESET_CYCLES + STARTUP_WAIT + 500;
        while (!$feof(fd))
        begin
            code = $fgets(line, fd);
            if ((code <= 0) || (line.len() < 2) || (line[0] == "#"))
                continue;                  // blank or comment
            a    = '0;
            b    = '0;
            code = $sscanf(line, "%c %h %h", op, a, b);
            case (op)
                "D": dflt_words[a[4:0]] = b;  // default table rather than an operation
                "E": cycle_limit += int'(b - a + 1) * 40;
                "S": cycle_limit += 24;
                "N": cycle_limit += int'(a);
                "R": cycle_limit += RESET_CYCLES + STARTUP_WAIT + 10;
                default: cycle_limit += 10;   // bus writes with their gap
            endcase
            if (op != "D")
            begin
                op_q.push_back(op);
                arg_a_q.push_back(a);
                arg_b_q.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    // ****************************************
    // main sequence
    // ****************************************
    initial
    begin
        resetS  = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        void'($urandom(32'h604f));
        load_cases();
        apply_reset();
        for (int k = 0; k < op_q.size(); k++)
        begin
            case (op_q[k])
                "W":
                begin
                    idle_gap();
                    bus_write(arg_a_q[k][4:0], arg_b_q[k]);
                    if (arg_a_q[k] < NUM_WORDS)
                        exp_words[arg_a_q[k][4:0]] = arg_b_q[k];  // higher addresses are dropped
                end
                "G":
                begin
                    idle_gap();
                    bus_write(clk_synth_pkg::CTRL_ADDR, {31'd0, arg_a_q[k][0]});
                end
                "E": expect_frames(int'(arg_a_q[k]), int'(arg_b_q[k]));
                "S": expect_sync(int'(arg_a_q[k]));
                "N": expect_quiet(int'(arg_a_q[k]));
                "R":
                begin
                    idle_gap();
                    apply_reset();         // startup reruns from here
                end
                default:
                begin
                    $display("unknown operation in the case file at entry %0d", k);
                    $display("TEST FAIL");
                    $fatal(1, "bad case file");
                end
            endcase
        end
        $display("%0d operations done in %0d cycles", op_q.size(), cycle_cnt);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: vlog.f
design/clk_synth_pkg.sv
design/cfg_reg_bank.sv
design/startup_seq.sv
design/write_seq.sv
design/serial_shifter.sv
design/clk_synth_cfg.sv
tests/tb_clk_synth_cfg.sv
